// File: Bender.yml
package:
  name: axi_isolate

export_include_dirs:
  - src

sources:
  - files:
      - src/axi_iso_pkg.sv
      - src/pending_counter.sv
      - src/write_isolator.sv
      - src/read_isolator.sv
      - src/axi_isolate.sv
  - target: test
    files:
      - tests/axi_isolate_props.sv
      - tests/tb_axi_isolate.sv

// File: axi_isolate.f
+incdir+src
src/axi_iso_pkg.sv
src/pending_counter.sv
src/write_isolator.sv
src/read_isolator.sv
src/axi_isolate.sv
tests/axi_isolate_props.sv
tests/tb_axi_isolate.sv

// File: src/axi_iso_macros.svh
////////////////////
// Width, pending limit and counter width macros for the AXI isolator
////////////////////

`ifndef AXI_ISO_MACROS_SVH
`define AXI_ISO_MACROS_SVH

// Channel field widths
`define AXI_ISO_ID_W   4
`define AXI_ISO_ADDR_W 32
`define AXI_ISO_DATA_W 32
`define AXI_ISO_ATOP_W 6

// Atop bit that asks for a read response
`define AXI_ISO_ATOP_R_RESP 5

// Open transactions allowed per channel
`define AXI_ISO_NUM_PENDING 4

// Bits for 0 up to the limit, plus one spare bit for injected atomic counts
`define AXI_ISO_CNT_W ($clog2(`AXI_ISO_NUM_PENDING + 1) + 1)

`endif

// File: src/axi_iso_pkg.sv
////////////////////
// Channel field types, counter type and isolation state enum
////////////////////

`default_nettype none

`include "axi_iso_macros.svh"

package axi_iso_pkg;

  // AXI channel fields that travel through the isolator
  typedef logic [`AXI_ISO_ID_W-1:0]   id_t;
  typedef logic [`AXI_ISO_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_ISO_DATA_W-1:0] data_t;
  typedef logic [`AXI_ISO_ATOP_W-1:0] atop_t;
  typedef logic [1:0]                 resp_t;

  // Open transaction count
  typedef logic [`AXI_ISO_CNT_W-1:0] cnt_t;

  // Per-half address channel FSM
  typedef enum logic [1:0] {
    NORMAL,
    HOLD,
    DRAIN,
    ISOLATED
  } iso_state_e;

endpackage

`default_nettype wire

// File: src/axi_isolate.sv
////////////////////
// AXI4 isolator top, write and read halves plus isolated_o
////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi_isolate (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 isolate_i,
  output logic                 isolated_o,
  // Slave port, write
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_iso_pkg::id_t     slv_aw_id_i,
  input  axi_iso_pkg::addr_t   slv_aw_addr_i,
  input  axi_iso_pkg::atop_t   slv_aw_atop_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  input  axi_iso_pkg::data_t   slv_w_data_i,
  input  logic                 slv_w_last_i,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axi_iso_pkg::id_t     slv_b_id_o,
  output axi_iso_pkg::resp_t   slv_b_resp_o,
  // Slave port, read
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axi_iso_pkg::id_t     slv_ar_id_i,
  input  axi_iso_pkg::addr_t   slv_ar_addr_i,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output axi_iso_pkg::id_t     slv_r_id_o,
  output axi_iso_pkg::data_t   slv_r_data_o,
  output axi_iso_pkg::resp_t   slv_r_resp_o,
  output logic                 slv_r_last_o,
  // Master port, write
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output axi_iso_pkg::id_t     mst_aw_id_o,
  output axi_iso_pkg::addr_t   mst_aw_addr_o,
  output axi_iso_pkg::atop_t   mst_aw_atop_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  output axi_iso_pkg::data_t   mst_w_data_o,
  output logic                 mst_w_last_o,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  input  axi_iso_pkg::id_t     mst_b_id_i,
  input  axi_iso_pkg::resp_t   mst_b_resp_i,
  // Master port, read
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  output axi_iso_pkg::id_t     mst_ar_id_o,
  output axi_iso_pkg::addr_t   mst_ar_addr_o,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o,
  input  axi_iso_pkg::id_t     mst_r_id_i,
  input  axi_iso_pkg::data_t   mst_r_data_i,
  input  axi_iso_pkg::resp_t   mst_r_resp_i,
  input  logic                 mst_r_last_i
);

  // Atomic read counts cross from the write half to the read half
  logic atop_inject;
  logic atop_block;
  logic wr_isolated;
  logic rd_isolated;

  ////////////////////
  // Halves
  ////////////////////

  // Channel ports match by name
  write_isolator write_isolator_i (
    .atop_block_i  ( atop_block  ),
    .atop_inject_o ( atop_inject ),
    .wr_isolated_o ( wr_isolated ),
    .*
  );

  read_isolator read_isolator_i (
    .atop_inject_i ( atop_inject ),
    .atop_block_o  ( atop_block  ),
    .rd_isolated_o ( rd_isolated ),
    .*
  );

  // Isolated only once both sides have drained
  assign isolated_o = wr_isolated && rd_isolated;

endmodule

`default_nettype wire

// File: src/pending_counter.sv
////////////////////
// Up/down counter of open transactions with full and empty flags
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_iso_macros.svh"

module pending_counter #(
  parameter int unsigned LIMIT = `AXI_ISO_NUM_PENDING
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              inc_i,
  input  logic              inc_extra_i,
  input  logic              dec_i,
  output axi_iso_pkg::cnt_t count_o,
  output logic              full_o,
  output logic              empty_o
);

  axi_iso_pkg::cnt_t count_q;
  axi_iso_pkg::cnt_t count_d;

  // Both increments and the decrement may land in one cycle
  always_comb begin
    count_d = count_q
            + axi_iso_pkg::cnt_t'(inc_i)
            + axi_iso_pkg::cnt_t'(inc_extra_i)
            - axi_iso_pkg::cnt_t'(dec_i);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign count_o = count_q;
  // Full once the limit is reached, injected counts may push past it
  assign full_o  = (count_q >= axi_iso_pkg::cnt_t'(LIMIT));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

// File: src/read_isolator.sv
////////////////////
// Read half of the isolator
// AR FSM, R bookkeeping and injected atomic counts
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_iso_macros.svh"

module read_isolator (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 isolate_i,
  // Slave side
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axi_iso_pkg::id_t     slv_ar_id_i,
  input  axi_iso_pkg::addr_t   slv_ar_addr_i,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output axi_iso_pkg::id_t     slv_r_id_o,
  output axi_iso_pkg::data_t   slv_r_data_o,
  output axi_iso_pkg::resp_t   slv_r_resp_o,
  output logic                 slv_r_last_o,
  // Master side
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  output axi_iso_pkg::id_t     mst_ar_id_o,
  output axi_iso_pkg::addr_t   mst_ar_addr_o,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o,
  input  axi_iso_pkg::id_t     mst_r_id_i,
  input  axi_iso_pkg::data_t   mst_r_data_i,
  input  axi_iso_pkg::resp_t   mst_r_resp_i,
  input  logic                 mst_r_last_i,
  // Link to the write half
  input  logic                 atop_inject_i,
  output logic                 atop_block_o,
  output logic                 rd_isolated_o
);

  axi_iso_pkg::iso_state_e state_q;
  axi_iso_pkg::iso_state_e state_d;

  axi_iso_pkg::cnt_t ar_cnt;
  logic              ar_full;
  logic              ar_empty;
  logic              ar_accept;
  logic              r_last_done;

  // Same counting point as the write half
  assign ar_accept   = mst_ar_valid_o && (state_q == axi_iso_pkg::NORMAL);
  assign r_last_done = mst_r_valid_i && mst_r_ready_o && mst_r_last_i;

  // AR to R last, atomic writes add their R burst on the extra input
  pending_counter #(
    .LIMIT ( `AXI_ISO_NUM_PENDING )
  ) ar_counter_i (
    .clk_i       ( clk_i         ),
    .reset_i     ( reset_i       ),
    .inc_i       ( ar_accept     ),
    .inc_extra_i ( atop_inject_i ),
    .dec_i       ( r_last_done   ),
    .count_o     ( ar_cnt        ),
    .full_o      ( ar_full       ),
    .empty_o     ( ar_empty      )
  );

  // Spare counter bit leaves room up to twice the limit for atomics
  assign atop_block_o = (ar_cnt >= axi_iso_pkg::cnt_t'(2 * `AXI_ISO_NUM_PENDING));

  ////////////////////
  // AR and R channels
  ////////////////////

  always_comb begin
    state_d = state_q;
    mst_ar_valid_o = slv_ar_valid_i;
    mst_ar_id_o    = slv_ar_id_i;
    mst_ar_addr_o  = slv_ar_addr_i;
    slv_ar_ready_o = mst_ar_ready_i;
    slv_r_valid_o  = mst_r_valid_i;
    slv_r_id_o     = mst_r_id_i;
    slv_r_data_o   = mst_r_data_i;
    slv_r_resp_o   = mst_r_resp_i;
    slv_r_last_o   = mst_r_last_i;
    mst_r_ready_o  = slv_r_ready_i;

    unique case (state_q)
      axi_iso_pkg::NORMAL: begin
        if (ar_full) begin
          mst_ar_valid_o = 1'b0;
          slv_ar_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = axi_iso_pkg::DRAIN;
          end
        end else if (slv_ar_valid_i && !mst_ar_ready_i) begin
          state_d = axi_iso_pkg::HOLD;
        end else if (isolate_i) begin
          state_d = axi_iso_pkg::DRAIN;
        end
      end
      axi_iso_pkg::HOLD: begin
        mst_ar_valid_o = 1'b1;
        if (mst_ar_ready_i) begin
          state_d = isolate_i ? axi_iso_pkg::DRAIN : axi_iso_pkg::NORMAL;
        end
      end
      axi_iso_pkg::DRAIN: begin
        mst_ar_valid_o = 1'b0;
        mst_ar_id_o    = '0;
        mst_ar_addr_o  = '0;
        slv_ar_ready_o = 1'b0;
        // Wait for every R last, injected ones included
        if (ar_empty) begin
          state_d = axi_iso_pkg::ISOLATED;
        end
      end
      axi_iso_pkg::ISOLATED: begin
        mst_ar_valid_o = 1'b0;
        mst_ar_id_o    = '0;
        mst_ar_addr_o  = '0;
        slv_ar_ready_o = 1'b0;
        slv_r_valid_o  = 1'b0;
        slv_r_id_o     = '0;
        slv_r_data_o   = '0;
        slv_r_resp_o   = '0;
        slv_r_last_o   = 1'b0;
        mst_r_ready_o  = 1'b0;
        if (!isolate_i) begin
          state_d = axi_iso_pkg::NORMAL;
        end
      end
      default: begin
        state_d = axi_iso_pkg::ISOLATED;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= axi_iso_pkg::ISOLATED;
    end else begin
      state_q <= state_d;
    end
  end

  assign rd_isolated_o = (state_q == axi_iso_pkg::ISOLATED);

endmodule

`default_nettype wire

// File: src/write_isolator.sv
////////////////////
// Write half of the isolator
// AW FSM, W gate, AW/B and AW/W-last bookkeeping, atomic read detection
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_iso_macros.svh"

module write_isolator (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 isolate_i,
  // Slave side
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_iso_pkg::id_t     slv_aw_id_i,
  input  axi_iso_pkg::addr_t   slv_aw_addr_i,
  input  axi_iso_pkg::atop_t   slv_aw_atop_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  input  axi_iso_pkg::data_t   slv_w_data_i,
  input  logic                 slv_w_last_i,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axi_iso_pkg::id_t     slv_b_id_o,
  output axi_iso_pkg::resp_t   slv_b_resp_o,
  // Master side
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output axi_iso_pkg::id_t     mst_aw_id_o,
  output axi_iso_pkg::addr_t   mst_aw_addr_o,
  output axi_iso_pkg::atop_t   mst_aw_atop_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  output axi_iso_pkg::data_t   mst_w_data_o,
  output logic                 mst_w_last_o,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  input  axi_iso_pkg::id_t     mst_b_id_i,
  input  axi_iso_pkg::resp_t   mst_b_resp_i,
  // Link to the read half
  input  logic                 atop_block_i,
  output logic                 atop_inject_o,
  output logic                 wr_isolated_o
);

  axi_iso_pkg::iso_state_e state_q;
  axi_iso_pkg::iso_state_e state_d;

  axi_iso_pkg::cnt_t aw_cnt;
  axi_iso_pkg::cnt_t w_cnt;
  logic              aw_full;
  logic              w_full;
  logic              aw_accept;
  logic              w_last_done;
  logic              b_done;

  ////////////////////
  // Bookkeeping
  ////////////////////

  // Counted when first shown in NORMAL, HOLD keeps it up until ready
  assign aw_accept   = mst_aw_valid_o && (state_q == axi_iso_pkg::NORMAL);
  assign w_last_done = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
  assign b_done      = mst_b_valid_i && mst_b_ready_o;

  // Atomic with read response owes one R burst to the read half
  assign atop_inject_o = aw_accept && slv_aw_atop_i[`AXI_ISO_ATOP_R_RESP];

  // AW to B
  pending_counter #(
    .LIMIT ( `AXI_ISO_NUM_PENDING )
  ) aw_counter_i (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .inc_i       ( aw_accept ),
    .inc_extra_i ( 1'b0      ),
    .dec_i       ( b_done    ),
    .count_o     ( aw_cnt    ),
    .full_o      ( aw_full   ),
    .empty_o     (           )
  );

  // AW to W last
  pending_counter #(
    .LIMIT ( `AXI_ISO_NUM_PENDING )
  ) w_counter_i (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .inc_i       ( aw_accept   ),
    .inc_extra_i ( 1'b0        ),
    .dec_i       ( w_last_done ),
    .count_o     ( w_cnt       ),
    .full_o      ( w_full      ),
    .empty_o     (             )
  );

  ////////////////////
  // AW and B channels
  ////////////////////

  always_comb begin
    state_d = state_q;
    // Straight through by default
    mst_aw_valid_o = slv_aw_valid_i;
    mst_aw_id_o    = slv_aw_id_i;
    mst_aw_addr_o  = slv_aw_addr_i;
    mst_aw_atop_o  = slv_aw_atop_i;
    slv_aw_ready_o = mst_aw_ready_i;
    slv_b_valid_o  = mst_b_valid_i;
    slv_b_id_o     = mst_b_id_i;
    slv_b_resp_o   = mst_b_resp_i;
    mst_b_ready_o  = slv_b_ready_i;

    unique case (state_q)
      axi_iso_pkg::NORMAL: begin
        if (aw_full || w_full || atop_block_i) begin
          // Stall, no AW may open
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = axi_iso_pkg::DRAIN;
          end
        end else if (slv_aw_valid_i && !mst_aw_ready_i) begin
          state_d = axi_iso_pkg::HOLD;
        end else if (isolate_i) begin
          state_d = axi_iso_pkg::DRAIN;
        end
      end
      axi_iso_pkg::HOLD: begin
        // Keep valid up even if the slave side drops it
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          state_d = isolate_i ? axi_iso_pkg::DRAIN : axi_iso_pkg::NORMAL;
        end
      end
      axi_iso_pkg::DRAIN: begin
        mst_aw_valid_o = 1'b0;
        mst_aw_id_o    = '0;
        mst_aw_addr_o  = '0;
        mst_aw_atop_o  = '0;
        slv_aw_ready_o = 1'b0;
        // B still flows so open bursts can finish
        if ((aw_cnt == '0) && (w_cnt == '0)) begin
          state_d = axi_iso_pkg::ISOLATED;
        end
      end
      axi_iso_pkg::ISOLATED: begin
        mst_aw_valid_o = 1'b0;
        mst_aw_id_o    = '0;
        mst_aw_addr_o  = '0;
        mst_aw_atop_o  = '0;
        slv_aw_ready_o = 1'b0;
        slv_b_valid_o  = 1'b0;
        slv_b_id_o     = '0;
        slv_b_resp_o   = '0;
        mst_b_ready_o  = 1'b0;
        if (!isolate_i) begin
          state_d = axi_iso_pkg::NORMAL;
        end
      end
      default: begin
        state_d = axi_iso_pkg::ISOLATED;
      end
    endcase
  end

  ////////////////////
  // W channel gate
  ////////////////////

  // Cut while no burst is open, unless an AW opens one this cycle
  always_comb begin
    mst_w_valid_o = slv_w_valid_i;
    mst_w_data_o  = slv_w_data_i;
    mst_w_last_o  = slv_w_last_i;
    slv_w_ready_o = mst_w_ready_i;
    if ((w_cnt == '0) && !aw_accept) begin
      mst_w_valid_o = 1'b0;
      mst_w_data_o  = '0;
      mst_w_last_o  = 1'b0;
      slv_w_ready_o = 1'b0;
    end
  end

  // Comes up in ISOLATED after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= axi_iso_pkg::ISOLATED;
    end else begin
      state_q <= state_d;
    end
  end

  assign wr_isolated_o = (state_q == axi_iso_pkg::ISOLATED);

endmodule

`default_nettype wire

// File: tests/axi_isolate_props.sv
////////////////////
// Concurrent checks on counters, silenced outputs and HOLD
// Bound into both isolator halves
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_iso_macros.svh"

module axi_isolate_props (
  input logic                    clk_i,
  input logic                    reset_i,
  input axi_iso_pkg::iso_state_e state_i,
  input axi_iso_pkg::cnt_t       cnt_a_i,
  input axi_iso_pkg::cnt_t       cnt_b_i,
  input logic                    addr_valid_i,
  input logic                    addr_ready_i,
  // High when any output that must be quiet in ISOLATED is high
  input logic                    leak_i
);

  // Never past twice the limit, so no wrap through the top
  assert property (@(posedge clk_i) disable iff (reset_i)
    (cnt_a_i <= 2 * `AXI_ISO_NUM_PENDING) && (cnt_b_i <= 2 * `AXI_ISO_NUM_PENDING))
    else $error("Pending counter above twice the limit");

  // From zero only upwards, at most two increments
  assert property (@(posedge clk_i) disable iff (reset_i)
    (cnt_a_i == '0) |=> (cnt_a_i <= 2))
    else $error("First counter wrapped below zero");

  assert property (@(posedge clk_i) disable iff (reset_i)
    (cnt_b_i == '0) |=> (cnt_b_i <= 2))
    else $error("Second counter wrapped below zero");

  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == axi_iso_pkg::ISOLATED) |-> !leak_i)
    else $error("Valid or ready active while isolated");

  // Master address valid, once shown, stays up until ready (covers entry into HOLD)
  assert property (@(posedge clk_i) disable iff (reset_i)
    (addr_valid_i && !addr_ready_i) |=> addr_valid_i)
    else $error("Address valid dropped before ready");

endmodule

bind write_isolator axi_isolate_props write_props_i (
  .clk_i        ( clk_i          ),
  .reset_i      ( reset_i        ),
  .state_i      ( state_q        ),
  .cnt_a_i      ( aw_cnt         ),
  .cnt_b_i      ( w_cnt          ),
  .addr_valid_i ( mst_aw_valid_o ),
  .addr_ready_i ( mst_aw_ready_i ),
  .leak_i       ( mst_aw_valid_o | mst_w_valid_o | mst_b_ready_o
                | slv_aw_ready_o | slv_w_ready_o | slv_b_valid_o )
);

bind read_isolator axi_isolate_props read_props_i (
  .clk_i        ( clk_i          ),
  .reset_i      ( reset_i        ),
  .state_i      ( state_q        ),
  .cnt_a_i      ( ar_cnt         ),
  .cnt_b_i      ( ar_cnt         ),
  .addr_valid_i ( mst_ar_valid_o ),
  .addr_ready_i ( mst_ar_ready_i ),
  .leak_i       ( mst_ar_valid_o | mst_r_ready_o | slv_ar_ready_o | slv_r_valid_o )
);

`default_nettype wire

// File: tests/tb_axi_isolate.sv
////////////////////
// Directed testbench for the AXI4 isolator
// Clock, reset, watchdog and one task per behavior
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_iso_macros.svh"

module tb_axi_isolate;

  localparam int unsigned CLK_PERIOD      = 8;
  localparam int unsigned NUM_TESTS       = 6;
  localparam int unsigned CYCLES_PER_TEST = 200;
  localparam int unsigned HANDSHAKE_LIMIT = 20;

  logic clk_i;
  logic reset_i;
  logic isolate_i;
  logic isolated_o;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  logic slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  logic mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  axi_iso_pkg::id_t   slv_aw_id_i, slv_b_id_o, slv_ar_id_i, slv_r_id_o;
  axi_iso_pkg::id_t   mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  axi_iso_pkg::addr_t slv_aw_addr_i, slv_ar_addr_i, mst_aw_addr_o, mst_ar_addr_o;
  axi_iso_pkg::atop_t slv_aw_atop_i, mst_aw_atop_o;
  axi_iso_pkg::data_t slv_w_data_i, slv_r_data_o, mst_w_data_o, mst_r_data_i;
  axi_iso_pkg::resp_t slv_b_resp_o, slv_r_resp_o, mst_b_resp_i, mst_r_resp_i;

  integer seed = 79;
  int     errors = 0;
  int     checks = 0;

  axi_isolate axi_isolate_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Ends a run that got stuck
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Inputs move 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  // One AW with its single W beat, both in the same cycle
  task automatic send_write(input axi_iso_pkg::atop_t atop);
    int unsigned        waited;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::addr_t addr;
    axi_iso_pkg::data_t data;
    waited = 0;
    id     = axi_iso_pkg::id_t'($random(seed));
    addr   = $random(seed);
    data   = $random(seed);
    slv_aw_valid_i = 1'b1;
    slv_aw_id_i    = id;
    slv_aw_addr_i  = addr;
    slv_aw_atop_i  = atop;
    slv_w_valid_i  = 1'b1;
    slv_w_data_i   = data;
    slv_w_last_i   = 1'b1;
    @(negedge clk_i);
    while (!(slv_aw_ready_o && slv_w_ready_o) && (waited < HANDSHAKE_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    assert (waited < HANDSHAKE_LIMIT) else begin
      $display("Timed out waiting for the AW and W handshake at %0d ns", $time);
      errors++;
    end
    // Payload must match in the handshake cycle
    check_value("mst_aw_valid_o", 1'b1, mst_aw_valid_o);
    check_value("mst_aw_id_o", id, mst_aw_id_o);
    check_value("mst_aw_addr_o", addr, mst_aw_addr_o);
    check_value("mst_aw_atop_o", atop, mst_aw_atop_o);
    check_value("mst_w_valid_o", 1'b1, mst_w_valid_o);
    check_value("mst_w_data_o", data, mst_w_data_o);
    check_value("mst_w_last_o", 1'b1, mst_w_last_o);
    next_cycle();
    slv_aw_valid_i = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_w_last_i   = 1'b0;
  endtask

  task automatic send_read();
    int unsigned        waited;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::addr_t addr;
    waited = 0;
    id     = axi_iso_pkg::id_t'($random(seed));
    addr   = $random(seed);
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = addr;
    @(negedge clk_i);
    while (!slv_ar_ready_o && (waited < HANDSHAKE_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    assert (waited < HANDSHAKE_LIMIT) else begin
      $display("Timed out waiting for the AR handshake at %0d ns", $time);
      errors++;
    end
    check_value("mst_ar_valid_o", 1'b1, mst_ar_valid_o);
    check_value("mst_ar_id_o", id, mst_ar_id_o);
    check_value("mst_ar_addr_o", addr, mst_ar_addr_o);
    next_cycle();
    slv_ar_valid_i = 1'b0;
  endtask

  // Memory side answers with a B response
  task automatic return_b();
    int unsigned        waited;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::resp_t resp;
    waited = 0;
    id     = axi_iso_pkg::id_t'($random(seed));
    resp   = axi_iso_pkg::resp_t'($random(seed));
    mst_b_valid_i = 1'b1;
    mst_b_id_i    = id;
    mst_b_resp_i  = resp;
    @(negedge clk_i);
    while (!mst_b_ready_o && (waited < HANDSHAKE_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    assert (waited < HANDSHAKE_LIMIT) else begin
      $display("Timed out waiting for the B handshake at %0d ns", $time);
      errors++;
    end
    check_value("slv_b_valid_o", 1'b1, slv_b_valid_o);
    check_value("slv_b_id_o", id, slv_b_id_o);
    check_value("slv_b_resp_o", resp, slv_b_resp_o);
    next_cycle();
    mst_b_valid_i = 1'b0;
  endtask

  // Memory side answers with one R beat carrying last
  task automatic return_r();
    int unsigned        waited;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::data_t data;
    axi_iso_pkg::resp_t resp;
    waited = 0;
    id     = axi_iso_pkg::id_t'($random(seed));
    data   = $random(seed);
    resp   = axi_iso_pkg::resp_t'($random(seed));
    mst_r_valid_i = 1'b1;
    mst_r_id_i    = id;
    mst_r_data_i  = data;
    mst_r_resp_i  = resp;
    mst_r_last_i  = 1'b1;
    @(negedge clk_i);
    while (!mst_r_ready_o && (waited < HANDSHAKE_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    assert (waited < HANDSHAKE_LIMIT) else begin
      $display("Timed out waiting for the R handshake at %0d ns", $time);
      errors++;
    end
    check_value("slv_r_valid_o", 1'b1, slv_r_valid_o);
    check_value("slv_r_id_o", id, slv_r_id_o);
    check_value("slv_r_data_o", data, slv_r_data_o);
    check_value("slv_r_resp_o", resp, slv_r_resp_o);
    check_value("slv_r_last_o", 1'b1, slv_r_last_o);
    next_cycle();
    mst_r_valid_i = 1'b0;
    mst_r_last_i  = 1'b0;
  endtask

  task automatic hold_not_isolated(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value("isolated_o", 1'b0, isolated_o);
      next_cycle();
    end
  endtask

  // Called right after the edge that emptied the last counter
  task automatic expect_isolation_edge();
    @(negedge clk_i);
    check_value("isolated_o", 1'b0, isolated_o);
    next_cycle();
    @(negedge clk_i);
    check_value("isolated_o", 1'b1, isolated_o);
    next_cycle();
  endtask

  task automatic wait_for_isolated();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (!isolated_o && (waited < HANDSHAKE_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    assert (isolated_o) else begin
      $display("Timed out waiting for isolated_o at %0d ns", $time);
      errors++;
    end
    next_cycle();
  endtask

  // One edge with isolate_i low returns both halves to NORMAL
  task automatic release_isolation();
    isolate_i = 1'b0;
    next_cycle();
    @(negedge clk_i);
    check_value("isolated_o", 1'b0, isolated_o);
    next_cycle();
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_and_passthrough();
    int errors_before;
    errors_before = errors;
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("isolated_o", 1'b1, isolated_o);
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("isolated_o", 1'b1, isolated_o);
    next_cycle();
    @(negedge clk_i);
    check_value("isolated_o", 1'b0, isolated_o);
    next_cycle();
    send_write('0);
    return_b();
    send_read();
    return_r();
    report_test("Reset and passthrough", errors_before);
  endtask

  task automatic idle_isolation();
    int errors_before;
    errors_before = errors;
    isolate_i = 1'b1;
    @(negedge clk_i);
    check_value("isolated_o", 1'b0, isolated_o);
    next_cycle();
    @(negedge clk_i);
    check_value("isolated_o", 1'b0, isolated_o);
    next_cycle();
    @(negedge clk_i);
    check_value("isolated_o", 1'b1, isolated_o);
    next_cycle();
    // Slave side requests must go nowhere
    slv_aw_valid_i = 1'b1;
    slv_w_valid_i  = 1'b1;
    slv_ar_valid_i = 1'b1;
    @(negedge clk_i);
    check_value("slv_aw_ready_o", 1'b0, slv_aw_ready_o);
    check_value("slv_w_ready_o", 1'b0, slv_w_ready_o);
    check_value("slv_ar_ready_o", 1'b0, slv_ar_ready_o);
    check_value("mst_aw_valid_o", 1'b0, mst_aw_valid_o);
    check_value("mst_w_valid_o", 1'b0, mst_w_valid_o);
    check_value("mst_ar_valid_o", 1'b0, mst_ar_valid_o);
    next_cycle();
    slv_aw_valid_i = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_ar_valid_i = 1'b0;
    release_isolation();
    report_test("Idle isolation", errors_before);
  endtask

  task automatic drain_open_bursts();
    int errors_before;
    errors_before = errors;
    send_write('0);
    send_read();
    isolate_i = 1'b1;
    hold_not_isolated(3);
    return_b();
    // Read half still owes its R last
    hold_not_isolated(2);
    return_r();
    expect_isolation_edge();
    release_isolation();
    report_test("Drain of open bursts", errors_before);
  endtask

  task automatic read_capacity_limit();
    int                 errors_before;
    int                 i;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::addr_t addr;
    errors_before = errors;
    for (i = 0; i < `AXI_ISO_NUM_PENDING; i++) begin
      send_read();
    end
    id   = axi_iso_pkg::id_t'($random(seed));
    addr = $random(seed);
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = addr;
    @(negedge clk_i);
    check_value("slv_ar_ready_o", 1'b0, slv_ar_ready_o);
    check_value("mst_ar_valid_o", 1'b0, mst_ar_valid_o);
    next_cycle();
    // One R last frees a slot for the waiting AR
    return_r();
    @(negedge clk_i);
    check_value("slv_ar_ready_o", 1'b1, slv_ar_ready_o);
    check_value("mst_ar_valid_o", 1'b1, mst_ar_valid_o);
    check_value("mst_ar_id_o", id, mst_ar_id_o);
    check_value("mst_ar_addr_o", addr, mst_ar_addr_o);
    next_cycle();
    slv_ar_valid_i = 1'b0;
    for (i = 0; i < `AXI_ISO_NUM_PENDING; i++) begin
      return_r();
    end
    report_test("Read capacity limit", errors_before);
  endtask

  task automatic atomic_read_injection();
    int                 errors_before;
    axi_iso_pkg::atop_t atop;
    errors_before = errors;
    atop = axi_iso_pkg::atop_t'($random(seed));
    atop[`AXI_ISO_ATOP_R_RESP] = 1'b1;
    send_write(atop);
    isolate_i = 1'b1;
    hold_not_isolated(2);
    return_b();
    // The atomic's R burst is still open
    hold_not_isolated(3);
    return_r();
    expect_isolation_edge();
    release_isolation();
    report_test("Atomic read injection", errors_before);
  endtask

  task automatic backpressure_and_release();
    int                 errors_before;
    axi_iso_pkg::id_t   id;
    axi_iso_pkg::data_t data;
    errors_before = errors;
    id   = axi_iso_pkg::id_t'($random(seed));
    data = $random(seed);
    mst_aw_ready_i = 1'b0;
    slv_aw_valid_i = 1'b1;
    slv_aw_id_i    = id;
    slv_aw_addr_i  = $random(seed);
    slv_aw_atop_i  = '0;
    @(negedge clk_i);
    check_value("mst_aw_valid_o", 1'b1, mst_aw_valid_o);
    check_value("slv_aw_ready_o", 1'b0, slv_aw_ready_o);
    next_cycle();
    // Slave gives up and isolation is requested during HOLD
    slv_aw_valid_i = 1'b0;
    isolate_i      = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_value("mst_aw_valid_o", 1'b1, mst_aw_valid_o);
      check_value("mst_aw_id_o", id, mst_aw_id_o);
      next_cycle();
    end
    mst_aw_ready_i = 1'b1;
    @(negedge clk_i);
    check_value("mst_aw_valid_o", 1'b1, mst_aw_valid_o);
    next_cycle();
    @(negedge clk_i);
    check_value("mst_aw_valid_o", 1'b0, mst_aw_valid_o);
    next_cycle();
    // The held AW opened a W burst
    slv_w_valid_i = 1'b1;
    slv_w_data_i  = data;
    slv_w_last_i  = 1'b1;
    @(negedge clk_i);
    check_value("mst_w_valid_o", 1'b1, mst_w_valid_o);
    check_value("mst_w_data_o", data, mst_w_data_o);
    next_cycle();
    slv_w_valid_i = 1'b0;
    slv_w_last_i  = 1'b0;
    return_b();
    wait_for_isolated();
    release_isolation();
    send_write('0);
    return_b();
    send_read();
    return_r();
    report_test("Back-pressure and release", errors_before);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    isolate_i      = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_atop_i  = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_b_ready_i  = 1'b1;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_r_ready_i  = 1'b1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_ar_ready_i = 1'b1;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;

    reset_and_passthrough();
    idle_isolation();
    drain_open_bursts();
    read_capacity_limit();
    atomic_read_injection();
    backpressure_and_release();

    $display("Tests finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
